/* include/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath
`define XLEN            32
`define IMM_W           16

// General registers
`define REG_COUNT       8
`define REG_IDX_W       3

// Instruction memory and fetch
`define IMEM_ADDR_W     32
`define FETCH_BUF_DEPTH 2   // Entries including the outstanding request
`define RESET_PC        32'h0000_0000

`endif

/* design/cpu_pkg.sv */
`default_nettype none

`include "cpu_config.svh"

package cpu_pkg;

   // Encoding matches bits 31:28 of the instruction word
   typedef enum logic [3:0] {
      op_nop  = 4'd0,
      op_add  = 4'd1,
      op_sub  = 4'd2,
      op_and  = 4'd3,
      op_or   = 4'd4,
      op_xor  = 4'd5,
      op_shl  = 4'd6,
      op_shr  = 4'd7,
      op_movi = 4'd8
   } alu_op_e;

   typedef struct packed {
      logic [`IMEM_ADDR_W-1:0] addr;
   } imem_req_t;

   typedef struct packed {
      logic [`XLEN-1:0] instr;
   } imem_rsp_t;

   typedef struct packed {
      logic [`IMEM_ADDR_W-1:0] pc;
      logic [`XLEN-1:0]        instr;
   } fetch_item_t;

   typedef struct packed {
      alu_op_e                 op;
      logic [`REG_IDX_W-1:0]   dest;
      logic [`REG_IDX_W-1:0]   src_a;
      logic [`REG_IDX_W-1:0]   src_b;
      logic                    use_imm;
      logic [`XLEN-1:0]        imm;      // Already sign-extended
      logic [`IMEM_ADDR_W-1:0] pc;
   } decoded_t;

   typedef struct packed {
      alu_op_e               op;
      logic [`REG_IDX_W-1:0] dest;
      logic [`XLEN-1:0]      a;
      logic [`XLEN-1:0]      b;
   } issue_t;

   typedef struct packed {
      logic [`REG_IDX_W-1:0] rd;
      logic [`XLEN-1:0]      data;
   } retire_t;

endpackage

`default_nettype wire

/* design/fetch_unit.sv */
`default_nettype none

`include "cpu_config.svh"

module fetch_unit import cpu_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   output logic        imem_valid,
   input  logic        imem_ready,
   output imem_req_t   imem_addr,
   input  logic        imem_rsp_valid,
   output logic        imem_rsp_ready,
   input  imem_rsp_t   imem_rsp,
   output logic        f_valid,
   input  logic        f_ready,
   output fetch_item_t f_item
);

   localparam int DEPTH = `FETCH_BUF_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);
   localparam logic [`IMEM_ADDR_W-1:0] PC_STEP = 4;

   logic [`IMEM_ADDR_W-1:0] pc;
   logic                    outstanding;
   fetch_item_t             fbuf [DEPTH];
   logic [PTR_W-1:0]        wr_ptr;
   logic [PTR_W-1:0]        rd_ptr;
   logic [CNT_W-1:0]        count;
   logic [CNT_W-1:0]        count_next;
   logic                    req_fire;
   logic                    rsp_fire;
   logic                    pop;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign req_fire       = imem_valid & imem_ready;
   assign rsp_fire       = imem_rsp_valid & imem_rsp_ready;
   assign pop            = f_valid & f_ready;
   assign imem_rsp_ready = outstanding;  // Slot reserved at request time
   assign imem_addr.addr = pc;
   assign f_valid        = (count != '0);
   assign f_item         = fbuf[rd_ptr];
   assign count_next     = count + CNT_W'(rsp_fire) - CNT_W'(pop);

   always_ff @(posedge clk) begin
      if (reset) begin
         pc          <= `RESET_PC;
         imem_valid  <= 1'b0;
         outstanding <= 1'b0;
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
      end else begin
         count <= count_next;
         if (req_fire) begin
            pc          <= pc + PC_STEP;
            outstanding <= 1'b1;
         end else if (rsp_fire) begin
            outstanding <= 1'b0;
         end
         // Next request only once the last one is back and a slot is free
         if (req_fire)
            imem_valid <= 1'b0;
         else if (!imem_valid && (!outstanding || rsp_fire) && count_next < CNT_W'(DEPTH))
            imem_valid <= 1'b1;
         if (rsp_fire)
            wr_ptr <= ptr_inc(wr_ptr);
         if (pop)
            rd_ptr <= ptr_inc(rd_ptr);
      end
   end

   // Single outstanding request, so its address is one step behind pc
   always_ff @(posedge clk) begin
      if (rsp_fire) begin
         fbuf[wr_ptr].pc    <= pc - PC_STEP;
         fbuf[wr_ptr].instr <= imem_rsp.instr;
      end
   end

   a_rsp_has_req: assert property (@(posedge clk) disable iff (reset)
      imem_rsp_valid |-> outstanding)
      else $error("instruction response without an outstanding request");

endmodule

`default_nettype wire

/* design/decode_unit.sv */
`default_nettype none

`include "cpu_config.svh"

module decode_unit import cpu_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        f_valid,
   output logic        f_ready,
   input  fetch_item_t f_item,
   input  logic        busy_ahead,
   output logic        dec_wb_valid,
   output retire_t     dec_wb,
   output logic        d_valid,
   input  logic        d_ready,
   output decoded_t    d_uop
);

   decoded_t   dec;
   decoded_t   uop_q;
   logic       held;
   logic       is_movi;
   logic       consume;
   logic       f_fire;
   logic [3:0] raw_op;

   assign raw_op = f_item.instr[31:28];

   always_comb begin
      dec.op      = (raw_op <= op_movi) ? alu_op_e'(raw_op) : op_nop;  // Unused codes as nop
      dec.dest    = f_item.instr[27:25];
      dec.src_a   = f_item.instr[24:22];
      dec.src_b   = f_item.instr[21:19];
      dec.use_imm = f_item.instr[16];
      dec.imm     = {{(`XLEN - `IMM_W){f_item.instr[`IMM_W-1]}}, f_item.instr[`IMM_W-1:0]};
      dec.pc      = f_item.pc;
   end

   assign is_movi = (uop_q.op == op_movi);

   // movi is written here once nothing older can still write a register
   assign dec_wb_valid = held & is_movi & ~busy_ahead;
   assign dec_wb.rd    = uop_q.dest;
   assign dec_wb.data  = uop_q.imm;

   assign d_valid = held & ~is_movi;
   assign d_uop   = uop_q;

   assign consume = dec_wb_valid | (d_valid & d_ready);
   assign f_ready = ~held | consume;
   assign f_fire  = f_valid & f_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         held <= 1'b0;
      end else if (f_fire) begin
         held <= (dec.op != op_nop);  // nops vanish here
      end else if (consume) begin
         held <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (f_fire)
         uop_q <= dec;
   end

   // Back end stays empty through the cycle after a movi write
   a_movi_alone: assert property (@(posedge clk) disable iff (reset)
      dec_wb_valid |=> !busy_ahead)
      else $error("decode writeback overlaps work in the back end");

endmodule

`default_nettype wire

/* design/register_access.sv */
`default_nettype none

`include "cpu_config.svh"

module register_access import cpu_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     d_valid,
   output logic     d_ready,
   input  decoded_t d_uop,
   input  logic     wb_valid,
   input  retire_t  wb,
   output logic     r_valid,
   input  logic     r_ready,
   output issue_t   r_issue,
   output logic     busy_ahead
);

   logic [`XLEN-1:0]      regs [`REG_COUNT];
   logic [`REG_COUNT-1:0] scoreboard;
   logic [`REG_COUNT-1:0] sb_next;
   decoded_t              uop_q;
   logic                  held;
   logic                  hazard;
   logic                  out_free;
   logic                  issue;
   logic                  d_fire;

   // src_b only matters when the immediate is not taken
   assign hazard = scoreboard[uop_q.src_a]
                 | scoreboard[uop_q.dest]
                 | (~uop_q.use_imm & scoreboard[uop_q.src_b]);

   assign out_free   = ~r_valid | r_ready;
   assign issue      = held & ~hazard & out_free;
   assign d_ready    = ~held | issue;
   assign d_fire     = d_valid & d_ready;
   assign busy_ahead = held | (|scoreboard);

   always_comb begin
      sb_next = scoreboard;
      if (wb_valid)
         sb_next[wb.rd] = 1'b0;
      if (issue)
         sb_next[uop_q.dest] = 1'b1;  // Hazard keeps this off the register being cleared
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         held       <= 1'b0;
         r_valid    <= 1'b0;
         scoreboard <= '0;
         for (int i = 0; i < `REG_COUNT; i++)
            regs[i] <= '0;
      end else begin
         if (d_fire)
            held <= 1'b1;
         else if (issue)
            held <= 1'b0;

         if (issue)
            r_valid <= 1'b1;
         else if (r_ready)
            r_valid <= 1'b0;

         scoreboard <= sb_next;

         if (wb_valid)
            regs[wb.rd] <= wb.data;
      end
   end

   always_ff @(posedge clk) begin
      if (d_fire)
         uop_q <= d_uop;
      if (issue) begin
         r_issue.op   <= uop_q.op;
         r_issue.dest <= uop_q.dest;
         r_issue.a    <= regs[uop_q.src_a];
         r_issue.b    <= uop_q.use_imm ? uop_q.imm : regs[uop_q.src_b];
      end
   end

   // With work pending, every write comes from execute and must be one we issued
   a_wb_pending: assert property (@(posedge clk) disable iff (reset)
      (wb_valid && (|scoreboard)) |-> scoreboard[wb.rd])
      else $error("writeback to r%0d with no pending write", wb.rd);

endmodule

`default_nettype wire

/* design/execute_unit.sv */
`default_nettype none

`include "cpu_config.svh"

module execute_unit import cpu_pkg::*; (
   input  logic    clk,
   input  logic    reset,
   input  logic    r_valid,
   output logic    r_ready,
   input  issue_t  r_issue,
   output logic    e_valid,
   input  logic    wb_ready,
   output retire_t e_result
);

   localparam int SHAMT_W = $clog2(`XLEN);

   logic [`XLEN-1:0]   alu_out;
   logic [SHAMT_W-1:0] shamt;
   logic               r_fire;

   assign shamt   = r_issue.b[SHAMT_W-1:0];
   assign r_ready = ~e_valid | wb_ready;  // Result leaves in the same cycle
   assign r_fire  = r_valid & r_ready;

   always_comb begin
      case (r_issue.op)
         op_add:  alu_out = r_issue.a + r_issue.b;
         op_sub:  alu_out = r_issue.a - r_issue.b;
         op_and:  alu_out = r_issue.a & r_issue.b;
         op_or:   alu_out = r_issue.a | r_issue.b;
         op_xor:  alu_out = r_issue.a ^ r_issue.b;
         op_shl:  alu_out = r_issue.a << shamt;
         op_shr:  alu_out = r_issue.a >> shamt;  // Logical
         default: alu_out = '0;                  // nop and movi never get here
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         e_valid <= 1'b0;
      end else if (r_fire) begin
         e_valid <= 1'b1;
      end else if (wb_ready) begin
         e_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (r_fire) begin
         e_result.rd   <= r_issue.dest;
         e_result.data <= alu_out;
      end
   end

   a_hold_result: assert property (@(posedge clk) disable iff (reset)
      (e_valid && !wb_ready) |=> (e_valid && $stable(e_result)))
      else $error("execute result changed under back-pressure");

endmodule

`default_nettype wire

/* design/pipeline_top.sv */
`default_nettype none

module pipeline_top import cpu_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   output logic      imem_valid,
   input  logic      imem_ready,
   output imem_req_t imem_addr,
   input  logic      imem_rsp_valid,
   output logic      imem_rsp_ready,
   input  imem_rsp_t imem_rsp,
   output logic      retire_valid,
   output retire_t   retire
);

   logic        f_valid;
   logic        f_ready;
   fetch_item_t f_item;
   logic        d_valid;
   logic        d_ready;
   decoded_t    d_uop;
   logic        r_valid;
   logic        r_ready;
   issue_t      r_issue;
   logic        e_valid;
   logic        wb_ready;
   retire_t     e_result;
   logic        dec_wb_valid;
   retire_t     dec_wb;
   logic        busy_ahead;
   logic        wb_valid;
   retire_t     wb;

   fetch_unit uut_fetch (
      .clk(clk), .reset(reset),
      .imem_valid(imem_valid), .imem_ready(imem_ready), .imem_addr(imem_addr),
      .imem_rsp_valid(imem_rsp_valid), .imem_rsp_ready(imem_rsp_ready), .imem_rsp(imem_rsp),
      .f_valid(f_valid), .f_ready(f_ready), .f_item(f_item)
   );

   decode_unit uut_decode (
      .clk(clk), .reset(reset),
      .f_valid(f_valid), .f_ready(f_ready), .f_item(f_item),
      .busy_ahead(busy_ahead),
      .dec_wb_valid(dec_wb_valid), .dec_wb(dec_wb),
      .d_valid(d_valid), .d_ready(d_ready), .d_uop(d_uop)
   );

   register_access uut_register_access (
      .clk(clk), .reset(reset),
      .d_valid(d_valid), .d_ready(d_ready), .d_uop(d_uop),
      .wb_valid(wb_valid), .wb(wb),
      .r_valid(r_valid), .r_ready(r_ready), .r_issue(r_issue),
      .busy_ahead(busy_ahead)
   );

   execute_unit uut_execute (
      .clk(clk), .reset(reset),
      .r_valid(r_valid), .r_ready(r_ready), .r_issue(r_issue),
      .e_valid(e_valid), .wb_ready(wb_ready), .e_result(e_result)
   );

   // Decode write wins the register port
   assign wb_ready     = ~dec_wb_valid;
   assign wb_valid     = dec_wb_valid | (e_valid & wb_ready);
   assign wb           = dec_wb_valid ? dec_wb : e_result;
   assign retire_valid = wb_valid;
   assign retire       = wb;

endmodule

`default_nettype wire

/* test/tb_pipeline.sv */
`default_nettype none

`include "cpu_config.svh"

module tb_pipeline import cpu_pkg::*; ();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int RESET_CYCLES = 16;
   localparam int NUM_TESTS    = 6;

   logic      clk;
   logic      reset;
   logic      imem_valid;
   logic      imem_ready;
   imem_req_t imem_addr;
   logic      imem_rsp_valid;
   logic      imem_rsp_ready;
   imem_rsp_t imem_rsp;
   logic      retire_valid;
   retire_t   retire;

   logic [31:0] prog [256];
   int          prog_len;
   retire_t     exp_q [$];
   logic [31:0] prog_rng = 32'd82;
   logic [31:0] mem_rng = 32'd82;
   logic [31:0] rsp_addr;
   logic [1:0]  rsp_delay;
   logic        rsp_pending;
   imem_req_t   next_fetch;
   int          errors;
   int          retires_checked;
   bit          timed_out;

   pipeline_top u_dut (
      .clk(clk), .reset(reset),
      .imem_valid(imem_valid), .imem_ready(imem_ready), .imem_addr(imem_addr),
      .imem_rsp_valid(imem_rsp_valid), .imem_rsp_ready(imem_rsp_ready), .imem_rsp(imem_rsp),
      .retire_valid(retire_valid), .retire(retire)
   );

   always #10 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      return x;
   endfunction

   function automatic logic [31:0] enc(input logic [3:0] op, input int d, input int a,
                                       input int b, input logic ui, input logic [15:0] imm);
      return {op, d[2:0], a[2:0], b[2:0], 2'b00, ui, imm};
   endfunction

   function automatic logic [31:0] fetch_word(input logic [31:0] addr);
      return ((addr >> 2) < prog_len) ? prog[addr >> 2] : 32'h0;  // Past the end reads nop
   endfunction

   // Runs the program in order on a model register file
   function automatic void build_expected();
      logic [31:0] regs [`REG_COUNT];
      logic [31:0] w;
      logic [31:0] imm;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic        writes;
      retire_t     r;
      exp_q.delete();
      for (int i = 0; i < `REG_COUNT; i++)
         regs[i] = '0;
      for (int i = 0; i < prog_len; i++) begin
         w      = prog[i];
         imm    = {{16{w[15]}}, w[15:0]};
         a      = regs[w[24:22]];
         b      = w[16] ? imm : regs[w[21:19]];
         writes = 1'b1;
         case (w[31:28])
            op_add:  res = a + b;
            op_sub:  res = a - b;
            op_and:  res = a & b;
            op_or:   res = a | b;
            op_xor:  res = a ^ b;
            op_shl:  res = a << b[4:0];
            op_shr:  res = a >> b[4:0];
            op_movi: res = imm;
            default: writes = 1'b0;
         endcase
         if (writes) begin
            regs[w[27:25]] = res;
            r.rd   = w[27:25];
            r.data = res;
            exp_q.push_back(r);
         end
      end
   endfunction

   task automatic add_instr(input logic [31:0] w);
      prog[prog_len] = w;
      prog_len++;
   endtask

   task automatic load_program(input int t);
      logic [3:0] op;
      prog_len = 0;
      case (t)
         0: begin
            add_instr(enc(op_movi, 1, 0, 0, 1'b0, 16'd5));
            add_instr(enc(op_add, 2, 1, 1, 1'b0, 16'd0));
         end
         1: for (int i = 0; i < 12; i++)
            add_instr(enc(op_movi, i % 8, 0, 0, 1'b0, 16'(i * 3 + 1)));
         2: begin
            add_instr(enc(op_movi, 1, 0, 0, 1'b0, 16'hffff));
            add_instr(enc(op_nop, 2, 1, 1, 1'b0, 16'h1234));
            add_instr(enc(op_movi, 2, 0, 0, 1'b0, 16'h8000));
            add_instr(enc(4'hf, 3, 1, 2, 1'b1, 16'h0001));  // Unused opcode
            add_instr(enc(op_movi, 3, 0, 0, 1'b0, 16'h7fff));
            add_instr(enc(op_nop, 0, 0, 0, 1'b0, 16'h0));
         end
         3: begin
            add_instr(enc(op_movi, 1, 0, 0, 1'b0, 16'd7));
            add_instr(enc(op_movi, 2, 0, 0, 1'b0, 16'd3));
            add_instr(enc(op_add, 3, 1, 2, 1'b0, 16'd0));
            add_instr(enc(op_sub, 4, 3, 2, 1'b0, 16'd0));
            add_instr(enc(op_and, 5, 4, 1, 1'b0, 16'd0));
            add_instr(enc(op_or, 6, 5, 2, 1'b0, 16'd0));
            add_instr(enc(op_xor, 7, 6, 1, 1'b0, 16'd0));
            add_instr(enc(op_shl, 1, 7, 2, 1'b0, 16'd0));
            add_instr(enc(op_shr, 2, 1, 2, 1'b0, 16'd0));
            add_instr(enc(op_add, 3, 3, 3, 1'b0, 16'd0));
            add_instr(enc(op_sub, 3, 3, 1, 1'b0, 16'd0));
         end
         4: begin
            add_instr(enc(op_movi, 1, 0, 0, 1'b0, 16'd100));
            add_instr(enc(op_add, 2, 1, 0, 1'b1, 16'hfffb));
            add_instr(enc(op_sub, 3, 2, 0, 1'b1, 16'd200));
            add_instr(enc(op_and, 4, 3, 0, 1'b1, 16'h00f0));
            add_instr(enc(op_or, 5, 4, 0, 1'b1, 16'h8001));
            add_instr(enc(op_xor, 6, 5, 0, 1'b1, 16'h5555));
            add_instr(enc(op_shl, 7, 1, 0, 1'b1, 16'd3));
            add_instr(enc(op_shr, 7, 7, 0, 1'b1, 16'd2));
            add_instr(enc(op_add, 4, 1, 0, 1'b1, 16'd1));
            add_instr(enc(op_movi, 4, 0, 0, 1'b0, 16'd9));  // Same dest as the add above
            add_instr(enc(op_add, 5, 4, 4, 1'b0, 16'd0));
         end
         default: for (int i = 0; i < 200; i++) begin
            prog_rng = xorshift(prog_rng);
            op = prog_rng[31:28];
            if (op > 4'd9)
               op = op - 4'd8;  // Keep most draws on real ops
            add_instr({op, prog_rng[27:0]});
         end
      endcase
   endtask

   task automatic check_retire(input retire_t got, input retire_t exp);
      retires_checked++;
      if (got !== exp) begin
         $display("FAIL %0t: retire r%0d = %h, expected r%0d = %h",
                  $time, got.rd, got.data, exp.rd, exp.data);
         errors++;
      end
   endtask

   task automatic check_fetch_addr(input imem_req_t got, input imem_req_t exp);
      if (got !== exp) begin
         $display("FAIL %0t: fetch address %h, expected %h", $time, got.addr, exp.addr);
         errors++;
      end
   endtask

   // Instruction memory with random ready and latency
   always @(posedge clk) begin
      if (reset) begin
         imem_ready     <= 1'b0;
         imem_rsp_valid <= 1'b0;
         rsp_pending    = 1'b0;
      end else begin
         mem_rng = xorshift(mem_rng);
         imem_ready <= (mem_rng[1:0] != 2'b00);
         if (imem_rsp_valid && imem_rsp_ready)
            imem_rsp_valid <= 1'b0;
         if (imem_valid && imem_ready) begin
            rsp_pending = 1'b1;
            rsp_addr    = imem_addr.addr;
            rsp_delay   = mem_rng[9:8];
         end else if (rsp_pending && rsp_delay != 0) begin
            rsp_delay--;
         end else if (rsp_pending) begin
            imem_rsp_valid <= 1'b1;
            imem_rsp.instr <= fetch_word(rsp_addr);
            rsp_pending    = 1'b0;
         end
      end
   end

   always @(posedge clk) begin
      if (reset) begin
         next_fetch.addr = `RESET_PC;
      end else if (imem_valid && imem_ready) begin
         check_fetch_addr(imem_addr, next_fetch);
         next_fetch.addr = next_fetch.addr + 32'd4;
      end
   end

   always @(posedge clk) begin
      if (reset && retire_valid) begin
         $display("Retire seen while reset was asserted at %0t", $time);
         errors++;
      end else if (!reset && retire_valid) begin
         if (exp_q.size() == 0) begin
            $display("Unexpected retire of r%0d at %0t, nothing left to retire",
                     retire.rd, $time);
            errors++;
         end else begin
            check_retire(retire, exp_q.pop_front());
         end
      end
   end

   task automatic run_test(input int t, input string name);
      int cycles;
      int limit;
      int err0;
      int ret0;
      err0 = errors;
      ret0 = retires_checked;
      reset <= 1'b1;
      @(posedge clk);
      load_program(t);
      build_expected();
      repeat (RESET_CYCLES - 1) @(posedge clk);
      reset  <= 1'b0;
      cycles = RESET_CYCLES;
      limit  = 40 * prog_len + RESET_CYCLES;
      while (exp_q.size() != 0 && cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      if (exp_q.size() != 0) begin
         $display("Test %s timed out after %0d cycles, %0d expected retires never arrived",
                  name, cycles, exp_q.size());
         errors++;
         timed_out = 1'b1;
      end else begin
         repeat (20) @(posedge clk);  // Catch stray retires
      end
      $display("Test %0d %s %s, %0d retires checked", t, name,
               (errors == err0) ? "ok" : "errors", retires_checked - ret0);
   endtask

   initial begin
      string names [NUM_TESTS];
      int    t;
      names = '{"reset", "fetch_order", "movi_nop", "alu_rr", "alu_imm", "random"};
      clk            = 1'b0;
      reset          = 1'b1;
      imem_ready     = 1'b0;
      imem_rsp_valid = 1'b0;
      imem_rsp       = '0;
      errors         = 0;
      retires_checked = 0;
      timed_out      = 1'b0;
      prog_len       = 0;
      t = 0;
      while (t < NUM_TESTS && !timed_out) begin
         run_test(t, names[t]);
         t++;
      end
      $display("%0d tests run, %0d retires checked, %0d errors", t, retires_checked, errors);
      if (errors == 0 && !timed_out)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
design/cpu_pkg.sv
design/fetch_unit.sv
design/decode_unit.sv
design/register_access.sv
design/execute_unit.sv
design/pipeline_top.sv
test/tb_pipeline.sv

/* Bender.yml */
package:
  name: pipeline

export_include_dirs:
  - include

sources:
  - files:
      - design/cpu_pkg.sv
      - design/fetch_unit.sv
      - design/decode_unit.sv
      - design/register_access.sv
      - design/execute_unit.sv
      - design/pipeline_top.sv
  - target: test
    files:
      - test/tb_pipeline.sv
